// File: Makefile
TOP = tb_arcade_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module $(TOP) -f arcade_ctrl.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f arcade_ctrl.f

clean:
	rm -rf obj_dir

// File: arcade_ctrl.f
rtl/game_input_pkg.sv
rtl/rom_load_pkg.sv
rtl/hold_key_decoder.sv
rtl/coin_flow.sv
rtl/input_port_mapper.sv
rtl/rom_load_ctrl.sv
rtl/arcade_ctrl_top.sv
tests/tb_arcade_ctrl.sv

// File: rtl/arcade_ctrl_top.sv
// Control and loading side of the Kickman / Solar Fox / Draw Poker core.
// Connects key decoding, coin timers, input mapping and ROM load control.
// COIN_TIMER_LOAD sets the length of each coin phase.

module arcade_ctrl_top #(
	parameter logic [23:0] COIN_TIMER_LOAD = 24'h3FFFFF
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	// Keyboard
	input  logic                  key_strobe_i,
	input  logic [7:0]            key_code_i,
	input  logic                  key_pressed_i,
	// Hopper drive from the game core
	input  logic                  hopper_drive_i,
	// Game selection and controls
	input  game_input_pkg::game_e game_i,
	input  logic                  up_i,
	input  logic                  down_i,
	input  logic                  left_i,
	input  logic                  right_i,
	input  logic                  fire_a_i,
	input  logic                  fire_b_i,
	input  logic                  fire_c_i,
	input  logic                  up2_i,
	input  logic                  down2_i,
	input  logic                  left2_i,
	input  logic                  right2_i,
	input  logic                  fire2_a_i,
	input  logic                  fire2_b_i,
	input  logic                  coin1_i,
	input  logic                  coin2_i,
	input  logic                  start1_i,
	input  logic                  start2_i,
	input  logic                  service_i,
	input  logic [game_input_pkg::SPIN_W-1:0] spin_angle_i,
	input  logic [game_input_pkg::DIP_W-1:0]  dip_i,
	// Loader
	input  logic                  ioctl_download_i,
	input  logic                  ioctl_wr_i,
	input  logic [7:0]            ioctl_index_i,
	input  logic [rom_load_pkg::DL_ADDR_W-1:0] ioctl_addr_i,
	input  logic                  user_reset_i,
	input  logic                  button_reset_i,
	// Game core side
	output logic [game_input_pkg::IN_W-1:0] input0_o,
	output logic [game_input_pkg::IN_W-1:0] input1_o,
	output logic [game_input_pkg::IN_W-1:0] input2_o,
	output logic [game_input_pkg::IN_W-1:0] input3_o,
	output logic signed [7:0]     spr_offset_o,
	output logic                  vflip_sel_o,
	output logic                  lamp_o,
	output logic                  load_req_o,
	output logic                  rom_wr_o,
	output logic                  nvram_wr_o,
	output logic                  rom_loaded_o,
	output logic                  core_reset_o,
	output logic [rom_load_pkg::GFX_ADDR_W-1:0] gfx_addr_o
);

	logic [game_input_pkg::HOLD_W-1:0] hold;
	logic coin_in_status;
	logic coin_release_status;
	logic hopper_release_status;

	hold_key_decoder u_hold_keys (
		.hold_o (hold),
		.*
	);

	// ====================
	// Draw Poker coin path
	// ====================
	coin_flow #(.COIN_TIMER_LOAD(COIN_TIMER_LOAD)) coin_in (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.coin_i           (coin1_i),
		.in_status_o      (coin_in_status),
		.release_status_o (coin_release_status)
	);

	// Hopper only reports its release phase
	coin_flow #(.COIN_TIMER_LOAD(COIN_TIMER_LOAD)) hopper (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.coin_i           (hopper_drive_i),
		.in_status_o      (),
		.release_status_o (hopper_release_status)
	);

	input_port_mapper u_mapper (
		.hold_i                  (hold),
		.coin_in_status_i        (coin_in_status),
		.coin_release_status_i   (coin_release_status),
		.hopper_release_status_i (hopper_release_status),
		.*
	);

	rom_load_ctrl u_rom_load (.*);

endmodule

// File: rtl/coin_flow.sv
// Coin mechanism model for Draw Poker. A trigger produces a timed
// coin-in pulse followed by an equally long release pulse.
// Used for both the coin switch and the payout hopper.

module coin_flow #(
	parameter logic [23:0] COIN_TIMER_LOAD = 24'h3FFFFF
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic coin_i,
	output logic in_status_o,
	output logic release_status_o
);

	typedef enum logic [1:0] {
		IDLE,
		COIN_IN,
		RELEASE
	} state_e;

	state_e      state;
	logic [23:0] timer;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state            <= IDLE;
			in_status_o      <= 1'b0;
			release_status_o <= 1'b0;
		end else begin
			case (state)
			IDLE: begin
				if (coin_i) begin
					timer       <= COIN_TIMER_LOAD;
					in_status_o <= 1'b1;
					state       <= COIN_IN;
				end
			end
			COIN_IN: begin
				if (timer != '0) begin
					timer <= timer - 1'b1;
				end else begin
					// Coin passed the switch, start release phase
					in_status_o      <= 1'b0;
					release_status_o <= 1'b1;
					timer            <= COIN_TIMER_LOAD;
					state            <= RELEASE;
				end
			end
			RELEASE: begin
				if (timer != '0) begin
					timer <= timer - 1'b1;
				end else begin
					release_status_o <= 1'b0;
					state            <= IDLE;
				end
			end
			default: state <= IDLE;
			endcase
		end
	end

	// The two phases of one coin never overlap
	a_phases_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(in_status_o && release_status_o));

endmodule

// File: rtl/game_input_pkg.sv
// Game selection, keyboard codes and input byte widths shared by the
// control decoding stages of the arcade core.

package game_input_pkg;

	// ====================
	// Game variant
	// ====================
	// Codes above DPOKER select no game and leave every byte released
	typedef enum logic [6:0] {
		KICKMAN  = 7'd0,
		SOLARFOX = 7'd1,
		DPOKER   = 7'd2
	} game_e;

	// ====================
	// Keyboard scan codes
	// ====================
	localparam logic [7:0] KEY_HOLD1 = 8'h1A;  // Z
	localparam logic [7:0] KEY_HOLD2 = 8'h22;  // X
	localparam logic [7:0] KEY_HOLD3 = 8'h21;  // C
	localparam logic [7:0] KEY_HOLD4 = 8'h2A;  // V
	localparam logic [7:0] KEY_HOLD5 = 8'h32;  // B

	// Input byte and control field widths
	localparam int IN_W   = 8;
	localparam int HOLD_W = 5;
	localparam int SPIN_W = 4;
	localparam int DIP_W  = 6;

	// Sprite horizontal shift
	localparam logic signed [7:0] SPR_OFFSET_DEFAULT  = 8'sd3;
	localparam logic signed [7:0] SPR_OFFSET_SOLARFOX = -8'sd3;

endpackage

// File: rtl/hold_key_decoder.sv
// Keyboard decoder for the five Draw Poker hold buttons.
// Each strobe with a hold key code updates that button level.

module hold_key_decoder (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        key_strobe_i,
	input  logic [7:0]  key_code_i,
	input  logic        key_pressed_i,
	output logic [game_input_pkg::HOLD_W-1:0] hold_o
);

	logic [game_input_pkg::HOLD_W-1:0] hold_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold_q <= '0;
		end else if (key_strobe_i) begin
			case (key_code_i)
			game_input_pkg::KEY_HOLD1: hold_q[0] <= key_pressed_i;
			game_input_pkg::KEY_HOLD2: hold_q[1] <= key_pressed_i;
			game_input_pkg::KEY_HOLD3: hold_q[2] <= key_pressed_i;
			game_input_pkg::KEY_HOLD4: hold_q[3] <= key_pressed_i;
			game_input_pkg::KEY_HOLD5: hold_q[4] <= key_pressed_i;
			default: ;  // Keys not used by the poker panel
			endcase
		end
	end

	assign hold_o = hold_q;

endmodule

// File: rtl/input_port_mapper.sv
// Maps player controls, DIP bits and coin status into the four
// active-low input bytes of the selected game, plus its video controls.
// All outputs are registered.

module input_port_mapper (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  game_input_pkg::game_e game_i,
	input  logic                  up_i,
	input  logic                  down_i,
	input  logic                  left_i,
	input  logic                  right_i,
	input  logic                  fire_a_i,
	input  logic                  fire_b_i,
	input  logic                  fire_c_i,
	input  logic                  up2_i,
	input  logic                  down2_i,
	input  logic                  left2_i,
	input  logic                  right2_i,
	input  logic                  fire2_a_i,
	input  logic                  fire2_b_i,
	input  logic                  coin1_i,
	input  logic                  coin2_i,
	input  logic                  start1_i,
	input  logic                  start2_i,
	input  logic                  service_i,
	input  logic [game_input_pkg::SPIN_W-1:0] spin_angle_i,
	input  logic [game_input_pkg::DIP_W-1:0]  dip_i,
	input  logic [game_input_pkg::HOLD_W-1:0] hold_i,
	input  logic                  coin_in_status_i,
	input  logic                  coin_release_status_i,
	input  logic                  hopper_release_status_i,
	output logic [game_input_pkg::IN_W-1:0] input0_o,
	output logic [game_input_pkg::IN_W-1:0] input1_o,
	output logic [game_input_pkg::IN_W-1:0] input2_o,
	output logic [game_input_pkg::IN_W-1:0] input3_o,
	output logic signed [7:0]     spr_offset_o,
	output logic                  vflip_sel_o,
	output logic                  lamp_o
);

	logic [game_input_pkg::IN_W-1:0] in0_d;
	logic [game_input_pkg::IN_W-1:0] in1_d;
	logic [game_input_pkg::IN_W-1:0] in2_d;
	logic [game_input_pkg::IN_W-1:0] in3_d;
	logic signed [7:0]               spr_d;
	logic                            vflip_d;
	logic                            lamp_d;
	logic                            bonus;

	assign bonus = ~dip_i[0] & ~dip_i[1];  // Solar Fox bonus life setting

	// ====================
	// Per-game mapping
	// ====================
	always_comb begin
		in0_d   = 8'hFF;
		in1_d   = 8'hFF;
		in2_d   = 8'hFF;
		in3_d   = 8'hFF;
		spr_d   = game_input_pkg::SPR_OFFSET_DEFAULT;
		vflip_d = 1'b0;
		lamp_d  = 1'b0;
		case (game_i)
		game_input_pkg::KICKMAN: begin
			in0_d = ~{service_i, 2'b00, down_i, start2_i, start1_i, coin2_i, coin1_i};
			in1_d = ~{4'h0, spin_angle_i};
			in3_d = {dip_i[0], 7'd0};  // Music switch, active high
		end
		game_input_pkg::SOLARFOX: begin
			spr_d = game_input_pkg::SPR_OFFSET_SOLARFOX;
			in0_d = ~{service_i, 2'b00, fire_a_i, start2_i | fire2_b_i,
				start1_i | fire_b_i, coin2_i, coin1_i};
			in1_d = ~{up2_i, down2_i, left2_i, right2_i, up_i, down_i, left_i, right_i};
			in2_d = ~{7'd0, fire2_a_i};
			in3_d = ~{3'b000, dip_i[2], 2'b00, bonus, dip_i[1]};
		end
		game_input_pkg::DPOKER: begin
			vflip_d = 1'b1;
			lamp_d  = dip_i[0];
			in0_d = ~{2'b11, down_i, up_i, hopper_release_status_i, 1'b0,
				coin_release_status_i, coin_in_status_i};
			// Stand, cancel and deal above the hold buttons
			in1_d = ~{fire_a_i, fire_b_i, fire_c_i, hold_i[4], hold_i[3],
				hold_i[2], hold_i[1], hold_i[0]};
			in3_d = ~{dip_i[5], dip_i[4], dip_i[3], 2'b11, dip_i[2], dip_i[1], 1'b0};
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			input0_o     <= 8'hFF;
			input1_o     <= 8'hFF;
			input2_o     <= 8'hFF;
			input3_o     <= 8'hFF;
			spr_offset_o <= game_input_pkg::SPR_OFFSET_DEFAULT;
			vflip_sel_o  <= 1'b0;
			lamp_o       <= 1'b0;
		end else begin
			input0_o     <= in0_d;
			input1_o     <= in1_d;
			input2_o     <= in2_d;
			input3_o     <= in3_d;
			spr_offset_o <= spr_d;
			vflip_sel_o  <= vflip_d;
			lamp_o       <= lamp_d;
		end
	end

	// Unknown game codes release every input
	a_unknown_game_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!(game_i inside {game_input_pkg::KICKMAN, game_input_pkg::SOLARFOX,
			game_input_pkg::DPOKER})
		|=> (input0_o == 8'hFF && input1_o == 8'hFF &&
			input2_o == 8'hFF && input3_o == 8'hFF));

endmodule

// File: rtl/rom_load_ctrl.sv
// Download tracking for the ROM loader. Toggles the memory load request
// per ROM write, routes ROM and NVRAM writes, rebases graphics addresses
// and keeps the game core in reset until a ROM is present.

module rom_load_ctrl (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               ioctl_download_i,
	input  logic                               ioctl_wr_i,
	input  logic [7:0]                         ioctl_index_i,
	input  logic [rom_load_pkg::DL_ADDR_W-1:0] ioctl_addr_i,
	input  logic                               user_reset_i,
	input  logic                               button_reset_i,
	output logic                               load_req_o,
	output logic                               rom_wr_o,
	output logic                               nvram_wr_o,
	output logic                               rom_loaded_o,
	output logic                               core_reset_o,
	output logic [rom_load_pkg::GFX_ADDR_W-1:0] gfx_addr_o
);

	logic                               wr_last;
	logic                               download_last;
	logic                               is_rom;
	logic [rom_load_pkg::DL_ADDR_W-1:0] dl_offset;

	assign is_rom = (ioctl_index_i == 8'(rom_load_pkg::ROM));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_last       <= 1'b0;
			download_last <= 1'b0;
			load_req_o    <= 1'b0;
			rom_loaded_o  <= 1'b0;
			core_reset_o  <= 1'b1;
		end else begin
			wr_last       <= ioctl_wr_i;
			download_last <= ioctl_download_i;
			if (ioctl_download_i && ioctl_wr_i && !wr_last && is_rom) begin
				load_req_o <= ~load_req_o;  // One toggle per written byte
			end
			if (download_last && !ioctl_download_i) begin
				rom_loaded_o <= 1'b1;
			end
			core_reset_o <= user_reset_i | button_reset_i | ~rom_loaded_o;
		end
	end

	// Write routing by download index
	assign rom_wr_o   = ioctl_wr_i && is_rom;
	assign nvram_wr_o = ioctl_wr_i && (ioctl_index_i == 8'(rom_load_pkg::NVRAM));

	assign dl_offset  = ioctl_addr_i - rom_load_pkg::GFX_BASE;
	assign gfx_addr_o = dl_offset[rom_load_pkg::GFX_ADDR_W-1:0];

	a_wr_routing_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_wr_o && nvram_wr_o));

endmodule

// File: rtl/rom_load_pkg.sv
// Download target indexes and address layout of the ROM image
// as delivered by the loader.

package rom_load_pkg;

	typedef enum logic [7:0] {
		ROM   = 8'h00,
		NVRAM = 8'hFF
	} load_index_e;

	localparam int DL_ADDR_W  = 25;
	localparam int GFX_ADDR_W = 17;

	// Graphics start right after both CPU images
	localparam logic [DL_ADDR_W-1:0] GFX_BASE = 25'h000C000;

endpackage

// File: tests/tb_arcade_ctrl.sv
// Testbench for arcade_ctrl_top with short coin timers.
// Reference models built from the control rules feed concurrent assertions.
// The stimulus only walks through the games, keys, coins and ROM downloads.

module tb_arcade_ctrl;

	localparam int COIN_LOAD       = 15;
	localparam int RAND_CYCLES     = 64;
	localparam int WATCHDOG_CYCLES = 4000;  // About eight times the full sequence
	localparam logic [7:0] HOLD_CODES [5] = '{8'h1A, 8'h22, 8'h21, 8'h2A, 8'h32};
	localparam logic [6:0] GAME_CODES [4] = '{7'd0, 7'd1, 7'd2, 7'd93};

	logic clk_sys = 1'b0;
	logic reset   = 1'b1;
	logic key_strobe_i, key_pressed_i, hopper_drive_i;
	logic [7:0] key_code_i;
	game_input_pkg::game_e game_i;
	logic up_i, down_i, left_i, right_i, fire_a_i, fire_b_i, fire_c_i;
	logic up2_i, down2_i, left2_i, right2_i, fire2_a_i, fire2_b_i;
	logic coin1_i, coin2_i, start1_i, start2_i, service_i;
	logic [3:0] spin_angle_i;
	logic [5:0] dip_i;
	logic ioctl_download_i, ioctl_wr_i, user_reset_i, button_reset_i;
	logic [7:0] ioctl_index_i;
	logic [24:0] ioctl_addr_i;
	logic [7:0] input0_o, input1_o, input2_o, input3_o;
	logic signed [7:0] spr_offset_o;
	logic vflip_sel_o, lamp_o, load_req_o, rom_wr_o, nvram_wr_o, rom_loaded_o, core_reset_o;
	logic [16:0] gfx_addr_o;

	// Reference model state
	logic [4:0] m_hold;
	logic [1:0] m_busy;
	int m_cnt [2];
	logic m_coin_in, m_coin_rel, m_hop_rel;
	logic m_wr_prev, m_dl_prev, m_load_req, m_loaded, m_core_reset;
	logic [7:0] exp_in0, exp_in1, exp_in2, exp_in3;
	logic signed [7:0] exp_spr;
	logic exp_vflip, exp_lamp;

	arcade_ctrl_top #(.COIN_TIMER_LOAD(24'(COIN_LOAD))) DUT (.*);

	always #4 clk_sys = ~clk_sys;

	// ====================
	// Reference models
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m_hold <= '0;
		end else if (key_strobe_i) begin
			for (int k = 0; k < 5; k++) begin
				if (key_code_i == HOLD_CODES[k]) m_hold[k] <= key_pressed_i;
			end
		end
	end

	// Index 0 is the coin switch, index 1 the hopper
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < 2; i++) begin
			if (reset) begin
				m_busy[i] <= 1'b0;
				m_cnt[i]  <= 0;
			end else if (!m_busy[i]) begin
				if ((i == 0) ? coin1_i : hopper_drive_i) begin
					m_busy[i] <= 1'b1;
					m_cnt[i]  <= 0;
				end
			end else if (m_cnt[i] == 2 * COIN_LOAD + 1) begin
				m_busy[i] <= 1'b0;  // Both phases over
			end else begin
				m_cnt[i] <= m_cnt[i] + 1;
			end
		end
	end

	assign m_coin_in  = m_busy[0] && (m_cnt[0] <= COIN_LOAD);
	assign m_coin_rel = m_busy[0] && (m_cnt[0] > COIN_LOAD);
	assign m_hop_rel  = m_busy[1] && (m_cnt[1] > COIN_LOAD);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m_wr_prev    <= 1'b0;
			m_dl_prev    <= 1'b0;
			m_load_req   <= 1'b0;
			m_loaded     <= 1'b0;
			m_core_reset <= 1'b1;
		end else begin
			m_wr_prev    <= ioctl_wr_i;
			m_dl_prev    <= ioctl_download_i;
			m_core_reset <= user_reset_i | button_reset_i | ~m_loaded;
			if (ioctl_download_i && ioctl_wr_i && !m_wr_prev && ioctl_index_i == 8'h00)
				m_load_req <= ~m_load_req;
			if (m_dl_prev && !ioctl_download_i) m_loaded <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		exp_in0   <= 8'hFF;  // Released unless a game claims the byte
		exp_in1   <= 8'hFF;
		exp_in2   <= 8'hFF;
		exp_in3   <= 8'hFF;
		exp_spr   <= 8'sd3;
		exp_vflip <= 1'b0;
		exp_lamp  <= 1'b0;
		if (!reset) begin
			case (game_i)
			game_input_pkg::KICKMAN: begin
				exp_in0 <= ~{service_i, 2'b00, down_i, start2_i, start1_i, coin2_i, coin1_i};
				exp_in1 <= {4'hF, ~spin_angle_i};
				exp_in3 <= {dip_i[0], 7'd0};
			end
			game_input_pkg::SOLARFOX: begin
				exp_spr <= -8'sd3;
				exp_in0 <= ~{service_i, 2'b00, fire_a_i, start2_i | fire2_b_i,
					start1_i | fire_b_i, coin2_i, coin1_i};
				exp_in1 <= ~{up2_i, down2_i, left2_i, right2_i, up_i, down_i, left_i, right_i};
				exp_in2 <= {7'h7F, ~fire2_a_i};
				exp_in3 <= ~{3'b000, dip_i[2], 2'b00, ~(dip_i[0] | dip_i[1]), dip_i[1]};
			end
			game_input_pkg::DPOKER: begin
				exp_vflip <= 1'b1;
				exp_lamp  <= dip_i[0];
				exp_in0 <= ~{2'b11, down_i, up_i, m_hop_rel, 1'b0, m_coin_rel, m_coin_in};
				exp_in1 <= ~{fire_a_i, fire_b_i, fire_c_i, m_hold};
				exp_in3 <= ~{dip_i[5], dip_i[4], dip_i[3], 2'b11, dip_i[2], dip_i[1], 1'b0};
			end
			default: ;
			endcase
		end
	end

	// ====================
	// Checks
	// ====================
	task automatic stop_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
		stop_with_failure();
	endtask

	a_after_reset: assert property (@(posedge clk_sys) $fell(reset) |->
		({input0_o, input1_o, input2_o, input3_o} == 32'hFFFFFFFF))
		else report_mismatch("input0_o..input3_o",
			$sampled({input0_o, input1_o, input2_o, input3_o}), 32'hFFFFFFFF);
	a_after_reset_ctrl: assert property (@(posedge clk_sys) $fell(reset) |->
		({load_req_o, core_reset_o} == 2'b01))
		else report_mismatch("{load_req_o, core_reset_o}",
			{30'd0, $sampled({load_req_o, core_reset_o})}, 32'h1);
	a_in0: assert property (@(posedge clk_sys) disable iff (reset) input0_o == exp_in0)
		else report_mismatch("input0_o", {24'd0, $sampled(input0_o)}, {24'd0, $sampled(exp_in0)});
	a_in1: assert property (@(posedge clk_sys) disable iff (reset) input1_o == exp_in1)
		else report_mismatch("input1_o", {24'd0, $sampled(input1_o)}, {24'd0, $sampled(exp_in1)});
	a_in2: assert property (@(posedge clk_sys) disable iff (reset) input2_o == exp_in2)
		else report_mismatch("input2_o", {24'd0, $sampled(input2_o)}, {24'd0, $sampled(exp_in2)});
	a_in3: assert property (@(posedge clk_sys) disable iff (reset) input3_o == exp_in3)
		else report_mismatch("input3_o", {24'd0, $sampled(input3_o)}, {24'd0, $sampled(exp_in3)});
	a_spr: assert property (@(posedge clk_sys) disable iff (reset) spr_offset_o == exp_spr)
		else report_mismatch("spr_offset_o", {24'd0, $sampled(spr_offset_o)},
			{24'd0, $sampled(exp_spr)});
	a_video: assert property (@(posedge clk_sys) disable iff (reset)
		{vflip_sel_o, lamp_o} == {exp_vflip, exp_lamp})
		else report_mismatch("{vflip_sel_o, lamp_o}", {30'd0, $sampled({vflip_sel_o, lamp_o})},
			{30'd0, $sampled({exp_vflip, exp_lamp})});
	a_load_req: assert property (@(posedge clk_sys) disable iff (reset) load_req_o == m_load_req)
		else report_mismatch("load_req_o", {31'd0, $sampled(load_req_o)},
			{31'd0, $sampled(m_load_req)});
	a_loaded: assert property (@(posedge clk_sys) disable iff (reset) rom_loaded_o == m_loaded)
		else report_mismatch("rom_loaded_o", {31'd0, $sampled(rom_loaded_o)},
			{31'd0, $sampled(m_loaded)});
	a_core_reset: assert property (@(posedge clk_sys) disable iff (reset)
		core_reset_o == m_core_reset)
		else report_mismatch("core_reset_o", {31'd0, $sampled(core_reset_o)},
			{31'd0, $sampled(m_core_reset)});
	a_wr_route: assert property (@(posedge clk_sys) disable iff (reset)
		{rom_wr_o, nvram_wr_o} == {ioctl_wr_i && ioctl_index_i == 8'h00,
		ioctl_wr_i && ioctl_index_i == 8'hFF})
		else report_mismatch("{rom_wr_o, nvram_wr_o}", {30'd0, $sampled({rom_wr_o, nvram_wr_o})},
			{30'd0, $sampled(ioctl_wr_i && ioctl_index_i == 8'h00),
			$sampled(ioctl_wr_i && ioctl_index_i == 8'hFF)});
	a_gfx_addr: assert property (@(posedge clk_sys) disable iff (reset)
		gfx_addr_o == 17'(ioctl_addr_i - 25'h000C000))
		else report_mismatch("gfx_addr_o", {15'd0, $sampled(gfx_addr_o)},
			{15'd0, 17'($sampled(ioctl_addr_i) - 25'h000C000)});

	// ====================
	// Stimulus
	// ====================
	task automatic set_controls(input logic [31:0] bits);
		up_i           <= bits[0];
		down_i         <= bits[1];
		left_i         <= bits[2];
		right_i        <= bits[3];
		fire_a_i       <= bits[4];
		fire_b_i       <= bits[5];
		fire_c_i       <= bits[6];
		up2_i          <= bits[7];
		down2_i        <= bits[8];
		left2_i        <= bits[9];
		right2_i       <= bits[10];
		fire2_a_i      <= bits[11];
		fire2_b_i      <= bits[12];
		coin1_i        <= bits[13];
		coin2_i        <= bits[14];
		start1_i       <= bits[15];
		start2_i       <= bits[16];
		service_i      <= bits[17];
		spin_angle_i   <= bits[21:18];
		dip_i          <= bits[27:22];
		hopper_drive_i <= bits[28];
	endtask

	task automatic strobe_key(input logic [7:0] code, input logic pressed);
		@(posedge clk_sys);
		key_code_i    <= code;
		key_pressed_i <= pressed;
		key_strobe_i  <= 1'b1;
		@(posedge clk_sys);
		key_strobe_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic write_byte(input logic [7:0] index, input logic [24:0] addr);
		@(posedge clk_sys);
		ioctl_index_i <= index;
		ioctl_addr_i  <= addr;
		ioctl_wr_i    <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic wait_core_release();
		int waited;
		waited = 0;
		while (core_reset_o && waited < 20) begin
			@(negedge clk_sys);
			waited++;
		end
		if (core_reset_o) begin
			$display("Core reset did not fall after the ROM download ended");
			stop_with_failure();
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		stop_with_failure();
	end

	initial begin
		void'($urandom(36));
		set_controls(32'd0);
		game_i           <= game_input_pkg::KICKMAN;
		key_strobe_i     <= 1'b0;
		key_code_i       <= 8'h00;
		key_pressed_i    <= 1'b0;
		ioctl_download_i <= 1'b0;
		ioctl_wr_i       <= 1'b0;
		ioctl_index_i    <= 8'h00;
		ioctl_addr_i     <= '0;
		user_reset_i     <= 1'b0;
		button_reset_i   <= 1'b0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		// Random controls for each game and one unknown code
		for (int g = 0; g < 4; g++) begin
			@(posedge clk_sys);
			game_i <= game_input_pkg::game_e'(GAME_CODES[g]);
			repeat (RAND_CYCLES) begin
				@(posedge clk_sys);
				set_controls($urandom);
			end
		end
		@(posedge clk_sys);
		set_controls(32'd0);
		game_i <= game_input_pkg::DPOKER;
		repeat (2 * (COIN_LOAD + 1) + 2) @(posedge clk_sys);  // Let both coin timers drain

		// Hold keys, then codes outside the poker panel
		for (int k = 0; k < 5; k++) strobe_key(HOLD_CODES[k], 1'b1);
		strobe_key(8'h1C, 1'b0);
		for (int k = 0; k < 5; k++) strobe_key(HOLD_CODES[k], 1'b0);
		strobe_key(8'h29, 1'b1);

		// Coin with a second coin while busy, then the hopper
		@(posedge clk_sys);
		coin1_i <= 1'b1;
		@(posedge clk_sys);
		coin1_i <= 1'b0;
		repeat (6) @(posedge clk_sys);
		coin1_i <= 1'b1;
		@(posedge clk_sys);
		coin1_i <= 1'b0;
		repeat (2 * (COIN_LOAD + 1)) @(posedge clk_sys);
		hopper_drive_i <= 1'b1;
		@(posedge clk_sys);
		hopper_drive_i <= 1'b0;
		repeat (2 * (COIN_LOAD + 1) + 2) @(posedge clk_sys);

		// ROM download over both sides of the graphics base
		@(posedge clk_sys);
		ioctl_download_i <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			if (i < 2) write_byte(8'h00, 25'($urandom_range(0, 32'hBFFF)));
			else write_byte(8'h00, 25'h000C000 + 25'($urandom_range(0, 32'h1FFFF)));
		end
		ioctl_download_i <= 1'b0;
		wait_core_release();

		// NVRAM download, plus one write to an index that is neither target
		@(posedge clk_sys);
		ioctl_download_i <= 1'b1;
		write_byte(8'hFF, 25'h0000010);
		write_byte(8'hFF, 25'h0000011);
		write_byte(8'h01, 25'h0000012);
		ioctl_download_i <= 1'b0;

		// Resets pull the core back into reset
		repeat (2) @(posedge clk_sys);
		user_reset_i <= 1'b1;
		@(posedge clk_sys);
		user_reset_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
		button_reset_i <= 1'b1;
		@(posedge clk_sys);
		button_reset_i <= 1'b0;
		repeat (4) @(posedge clk_sys);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
